// ==== rtl/flash_cmd_pkg.sv ====
package flash_cmd_pkg;

    localparam int OP_BITS   = 8;
    localparam int ADDR_BITS = 24;
    localparam int SR_BITS   = 8;       // Status register length

    ////////////////////
    // Single-bit SPI command set

    localparam logic [OP_BITS-1:0] OP_READ = 8'h03;    // Normal read
    localparam logic [OP_BITS-1:0] OP_WREN = 8'h06;    // Write enable
    localparam logic [OP_BITS-1:0] OP_SE   = 8'h20;    // 4 KB sector erase
    localparam logic [OP_BITS-1:0] OP_PP   = 8'h02;    // Page program
    localparam logic [OP_BITS-1:0] OP_RDSR = 8'h05;    // Read status register

    // Status register bits
    localparam int SR_WIP = 0;          // Write in progress

    ////////////////////
    // Shift frame

    // Opcode plus address, or one data word
    typedef union packed {
        struct packed {
            logic [OP_BITS-1:0]   opcode;
            logic [ADDR_BITS-1:0] addr;
        } cmd;
        logic [OP_BITS+ADDR_BITS-1:0] data;
    } flash_frame_u;

endpackage

// ==== rtl/spi_link_pkg.sv ====
package spi_link_pkg;

    // Data word carried by one read or program frame
    localparam int WORD_BITS = 32;

    // Bit-count ports between sequencer and engine
    localparam int CNT_BITS = 6;

    // SCK half-period in clock cycles
    localparam int DEFAULT_PRESCALE = 4;

endpackage

// ==== rtl/spi_engine.sv ====
module spi_engine
    import flash_cmd_pkg::*;
    import spi_link_pkg::*;
#(
    parameter int PRESCALE = DEFAULT_PRESCALE
) (
    input  logic                i_clk,
    input  logic                i_reset,

    input  logic                frame_go,
    input  logic                hold_cs,
    input  flash_frame_u        tx_frame,
    input  logic [CNT_BITS-1:0] tx_bits,
    input  logic [CNT_BITS-1:0] rx_bits,
    output logic                frame_done,
    output flash_frame_u        rx_frame,

    output logic                cs_n,
    output logic                sck,
    output logic                mosi,
    input  logic                miso
);

    localparam int PS_BITS = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam logic [PS_BITS-1:0] PS_MAX = PS_BITS'(PRESCALE - 1);

    localparam logic [1:0]
        ENG_IDLE  = 2'd0,
        ENG_SHIFT = 2'd1,
        ENG_GAP   = 2'd2;   // CS high before frame_done

    logic [1:0]           st;
    logic [PS_BITS-1:0]   ps_cnt;
    logic [CNT_BITS:0]    bit_cnt;      // Bits left, current one included
    logic [CNT_BITS:0]    total;
    logic [CNT_BITS-1:0]  rx_cnt;
    logic                 hold_q;
    logic [WORD_BITS-1:0] tx_sr;
    logic [WORD_BITS-1:0] rx_sr;

    logic tick;
    logic rise;
    logic fall;
    logic last_fall;
    logic gap_end;
    logic finish;

    assign total     = {1'b0, tx_bits} + {1'b0, rx_bits};
    assign tick      = (st == ENG_SHIFT) && (ps_cnt == PS_MAX);
    assign rise      = tick && !sck;
    assign fall      = tick && sck;
    assign last_fall = fall && (bit_cnt == 1);
    assign gap_end   = (st == ENG_GAP) && (ps_cnt == PS_MAX);
    assign finish    = (last_fall && hold_q) || gap_end;

    assign mosi = tx_sr[WORD_BITS-1];   // MSB first

    ////////////////////
    // Prescaler, SCK and chip select

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            st         <= ENG_IDLE;
            ps_cnt     <= '0;
            bit_cnt    <= '0;
            hold_q     <= 1'b0;
            sck        <= 1'b0;
            cs_n       <= 1'b1;
            frame_done <= 1'b0;
        end else begin
            frame_done <= finish;
            case (st)
                ENG_IDLE: begin
                    if (frame_go) begin
                        ps_cnt  <= '0;
                        bit_cnt <= total;
                        hold_q  <= hold_cs;
                        // A frame without bits only releases CS
                        if (total == 0) begin
                            st   <= ENG_GAP;
                            cs_n <= 1'b1;
                        end else begin
                            st   <= ENG_SHIFT;
                            cs_n <= 1'b0;
                        end
                    end
                end
                ENG_SHIFT: begin
                    if (tick) begin
                        ps_cnt <= '0;
                        sck    <= ~sck;
                        if (fall)
                            bit_cnt <= bit_cnt - 1'b1;
                    end else begin
                        ps_cnt <= ps_cnt + 1'b1;
                    end
                    if (last_fall) begin
                        if (hold_q) begin
                            st <= ENG_IDLE;     // Chained frame follows
                        end else begin
                            st   <= ENG_GAP;
                            cs_n <= 1'b1;
                        end
                    end
                end
                ENG_GAP: begin
                    if (gap_end) begin
                        ps_cnt <= '0;
                        st     <= ENG_IDLE;
                    end else begin
                        ps_cnt <= ps_cnt + 1'b1;
                    end
                end
                default: st <= ENG_IDLE;
            endcase
        end
    end

    ////////////////////
    // Shift registers

    always_ff @(posedge i_clk) begin
        if (st == ENG_IDLE && frame_go) begin
            tx_sr  <= tx_frame.data;
            rx_cnt <= rx_bits;
        end
        if (fall)
            tx_sr <= {tx_sr[WORD_BITS-2:0], 1'b0};     // Next bit with SCK low
        if (rise && bit_cnt <= {1'b0, rx_cnt})
            rx_sr <= {rx_sr[WORD_BITS-2:0], miso};
        if (finish)
            rx_frame.data <= rx_sr;                     // Right-aligned
    end

endmodule

// ==== rtl/flash_seq.sv ====
module flash_seq
    import flash_cmd_pkg::*;
    import spi_link_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,

    input  logic                 start,
    input  logic                 op_cont,
    input  logic                 is_write,
    input  logic [ADDR_BITS-1:0] address,
    input  logic [WORD_BITS-1:0] wr_word,
    output logic [WORD_BITS-1:0] rd_word,
    output logic                 rd_valid,
    output logic                 busy,

    output logic                 frame_go,
    output logic                 hold_cs,
    output flash_frame_u         tx_frame,
    output logic [CNT_BITS-1:0]  tx_bits,
    output logic [CNT_BITS-1:0]  rx_bits,
    input  logic                 frame_done,
    input  flash_frame_u         rx_frame
);

    localparam logic [7:0]
        IDLE         = 8'h01,
        READ_CMD     = 8'h02,
        READ_WORD    = 8'h04,
        WREN         = 8'h08,
        ERASE        = 8'h10,
        PROGRAM      = 8'h20,
        PROGRAM_DATA = 8'h40,
        POLL         = 8'h80;

    localparam logic [CNT_BITS-1:0] N_OP   = CNT_BITS'(OP_BITS);
    localparam logic [CNT_BITS-1:0] N_CMD  = CNT_BITS'(OP_BITS + ADDR_BITS);
    localparam logic [CNT_BITS-1:0] N_WORD = CNT_BITS'(WORD_BITS);
    localparam logic [CNT_BITS-1:0] N_STAT = CNT_BITS'(SR_BITS);

    logic [7:0]           state, state_next;
    logic                 phase, phase_next;        // 0 erase pass, 1 program pass
    logic                 rd_last, rd_last_next;    // Release frame in flight
    logic                 go_next;
    logic                 hold_next;
    flash_frame_u         frame_next;
    logic [CNT_BITS-1:0]  tx_bits_next;
    logic [CNT_BITS-1:0]  rx_bits_next;
    logic                 finish;

    logic [ADDR_BITS-1:0] addr_q;
    logic [WORD_BITS-1:0] word_q;
    logic [WORD_BITS-1:0] rd_word_q;

    function automatic flash_frame_u cmd_frame(input logic [OP_BITS-1:0]   op,
                                               input logic [ADDR_BITS-1:0] addr);
        flash_frame_u f;
        f.cmd.opcode = op;
        f.cmd.addr   = addr;
        return f;
    endfunction

    ////////////////////
    // Operation FSM

    always_comb begin
        state_next   = state;
        phase_next   = phase;
        rd_last_next = rd_last;
        go_next      = 1'b0;
        hold_next    = hold_cs;
        frame_next   = tx_frame;
        tx_bits_next = tx_bits;
        rx_bits_next = rx_bits;
        finish       = 1'b0;

        case (state)
            IDLE: begin
                if (start) begin
                    go_next      = 1'b1;
                    rx_bits_next = '0;
                    if (is_write) begin
                        state_next   = WREN;
                        phase_next   = 1'b0;
                        frame_next   = cmd_frame(OP_WREN, '0);
                        tx_bits_next = N_OP;
                        hold_next    = 1'b0;
                    end else begin
                        state_next   = READ_CMD;
                        frame_next   = cmd_frame(OP_READ, address);
                        tx_bits_next = N_CMD;
                        hold_next    = 1'b1;     // Data follows under the same CS
                    end
                end
            end
            READ_CMD: begin
                if (frame_done) begin
                    state_next   = READ_WORD;
                    go_next      = 1'b1;
                    rd_last_next = 1'b0;
                    tx_bits_next = '0;
                    rx_bits_next = N_WORD;
                    hold_next    = 1'b1;
                end
            end
            READ_WORD: begin
                if (frame_done) begin
                    if (rd_last) begin
                        state_next = IDLE;
                        finish     = 1'b1;
                    end else begin
                        // Next word, or an empty frame that raises CS
                        go_next      = 1'b1;
                        tx_bits_next = '0;
                        rx_bits_next = op_cont ? N_WORD : '0;
                        hold_next    = op_cont;
                        rd_last_next = !op_cont;
                    end
                end
            end
            WREN: begin
                if (frame_done) begin
                    go_next      = 1'b1;
                    tx_bits_next = N_CMD;
                    rx_bits_next = '0;
                    if (!phase) begin
                        state_next = ERASE;
                        frame_next = cmd_frame(OP_SE, addr_q);
                        hold_next  = 1'b0;
                    end else begin
                        state_next = PROGRAM;
                        frame_next = cmd_frame(OP_PP, addr_q);
                        hold_next  = 1'b1;
                    end
                end
            end
            PROGRAM: begin
                if (frame_done) begin
                    state_next      = PROGRAM_DATA;
                    go_next         = 1'b1;
                    frame_next.data = word_q;
                    tx_bits_next    = N_WORD;
                    hold_next       = 1'b0;
                end
            end
            ERASE, PROGRAM_DATA: begin
                if (frame_done) begin
                    state_next   = POLL;
                    go_next      = 1'b1;
                    frame_next   = cmd_frame(OP_RDSR, '0);
                    tx_bits_next = N_OP;
                    rx_bits_next = N_STAT;
                    hold_next    = 1'b0;
                end
            end
            POLL: begin
                if (frame_done) begin
                    if (rx_frame.data[SR_WIP]) begin
                        go_next = 1'b1;         // Same RDSR frame again
                    end else if (!phase) begin
                        state_next   = WREN;
                        phase_next   = 1'b1;
                        go_next      = 1'b1;
                        frame_next   = cmd_frame(OP_WREN, '0);
                        tx_bits_next = N_OP;
                        rx_bits_next = '0;
                    end else begin
                        state_next = IDLE;
                        finish     = 1'b1;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign busy     = (state != IDLE) && !finish;
    assign rd_valid = (state == READ_WORD) && frame_done && !rd_last;
    assign rd_word  = rd_valid ? rx_frame.data : rd_word_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= IDLE;
            phase    <= 1'b0;
            rd_last  <= 1'b0;
            frame_go <= 1'b0;
            hold_cs  <= 1'b0;
        end else begin
            state    <= state_next;
            phase    <= phase_next;
            rd_last  <= rd_last_next;
            frame_go <= go_next;
            hold_cs  <= hold_next;
        end
    end

    always_ff @(posedge i_clk) begin
        tx_frame <= frame_next;
        tx_bits  <= tx_bits_next;
        rx_bits  <= rx_bits_next;
        if (state == IDLE && start) begin
            addr_q <= address;
            word_q <= wr_word;
        end
        if (rd_valid)
            rd_word_q <= rx_frame.data;
    end

endmodule

// ==== rtl/flash_ctrl_top.sv ====
module flash_ctrl_top
    import flash_cmd_pkg::*;
    import spi_link_pkg::*;
#(
    parameter int PRESCALE = DEFAULT_PRESCALE
) (
    input  logic                 i_clk,
    input  logic                 i_reset,

    // Host side
    input  logic                 start,
    input  logic                 op_cont,
    input  logic                 is_write,
    input  logic [ADDR_BITS-1:0] address,
    input  logic [WORD_BITS-1:0] wr_word,
    output logic [WORD_BITS-1:0] rd_word,
    output logic                 rd_valid,
    output logic                 busy,

    // Flash pins
    output logic                 qspi_cs_n,
    output logic                 qspi_sck,
    output logic                 qspi_mosi,
    input  logic                 qspi_miso
);

    logic                frame_go;
    logic                hold_cs;
    logic                frame_done;
    flash_frame_u        tx_frame;
    flash_frame_u        rx_frame;
    logic [CNT_BITS-1:0] tx_bits;
    logic [CNT_BITS-1:0] rx_bits;

    flash_seq u_seq (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .start      (start),
        .op_cont    (op_cont),
        .is_write   (is_write),
        .address    (address),
        .wr_word    (wr_word),
        .rd_word    (rd_word),
        .rd_valid   (rd_valid),
        .busy       (busy),
        .frame_go   (frame_go),
        .hold_cs    (hold_cs),
        .tx_frame   (tx_frame),
        .tx_bits    (tx_bits),
        .rx_bits    (rx_bits),
        .frame_done (frame_done),
        .rx_frame   (rx_frame)
    );

    spi_engine #(
        .PRESCALE (PRESCALE)
    ) u_engine (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .frame_go   (frame_go),
        .hold_cs    (hold_cs),
        .tx_frame   (tx_frame),
        .tx_bits    (tx_bits),
        .rx_bits    (rx_bits),
        .frame_done (frame_done),
        .rx_frame   (rx_frame),
        .cs_n       (qspi_cs_n),
        .sck        (qspi_sck),
        .mosi       (qspi_mosi),
        .miso       (qspi_miso)
    );

endmodule

// ==== verification/flash_model.sv ====
module flash_model
    import flash_cmd_pkg::*;
#(
    parameter int MAX_WIP_POLLS = 5
) (
    input  logic cs_n,
    input  logic sck,
    input  logic mosi,
    output logic miso
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CMD_BITS = OP_BITS + ADDR_BITS;

    logic [7:0]           mem [logic [ADDR_BITS-1:0]];
    logic [OP_BITS-1:0]   op;
    logic [ADDR_BITS-1:0] addr;
    logic [ADDR_BITS-1:0] out_addr;
    logic [7:0]           in_byte;
    logic [7:0]           out_byte;
    int                   nbits;
    int                   out_cnt;
    bit                   out_on;
    bit                   wel;
    int                   wip_left;        // RDSR replies still reporting WIP
    int                   clear_replies;   // RDSR replies with WIP clear
    logic                 proto_err;
    string                proto_msg;

    function automatic logic [7:0] read_byte(input logic [ADDR_BITS-1:0] a);
        return mem.exists(a) ? mem[a] : 8'hFF;
    endfunction

    function automatic logic [7:0] status_byte();
        logic [7:0] sr;
        sr         = '0;
        sr[SR_WIP] = (wip_left > 0);
        return sr;
    endfunction

    task automatic load_word(input logic [ADDR_BITS-1:0] a, input logic [31:0] w);
        for (int i = 0; i < 4; i++)
            mem[a + ADDR_BITS'(i)] = w[31-8*i -: 8];  // First byte is the MSB
    endtask

    task automatic violation(input string msg);
        if (!proto_err)
            proto_msg = msg;
        proto_err = 1'b1;
    endtask

    initial begin
        miso          = 1'b0;
        nbits         = 0;
        out_cnt       = 0;
        out_on        = 1'b0;
        wel           = 1'b0;
        wip_left      = 0;
        clear_replies = 0;
        proto_err     = 1'b0;
    end

    ////////////////////
    // Command decode on SCK rise

    always @(posedge sck) begin
        if (!cs_n) begin
            if (nbits < OP_BITS)
                op = {op[OP_BITS-2:0], mosi};
            else if (nbits < CMD_BITS)
                addr = {addr[ADDR_BITS-2:0], mosi};
            else
                in_byte = {in_byte[6:0], mosi};
            nbits++;
            if (nbits == OP_BITS) begin
                if (wip_left > 0 && op != OP_RDSR)
                    violation($sformatf("opcode %02h sent while a write is in progress", op));
                if (op == OP_RDSR) begin
                    out_byte = status_byte();
                    out_cnt  = 0;
                    out_on   = 1'b1;
                end
            end
            if (nbits == CMD_BITS && op == OP_READ) begin
                out_addr = addr;
                out_byte = read_byte(addr);
                out_cnt  = 0;
                out_on   = 1'b1;
            end
            if (op == OP_PP && nbits > CMD_BITS && nbits % 8 == 0) begin
                mem[addr] = read_byte(addr) & in_byte;   // Program clears bits only
                addr = {addr[ADDR_BITS-1:8], addr[7:0] + 8'd1};
            end
        end
    end

    // Reply bits change after SCK falls
    always @(negedge sck) begin
        if (!cs_n && out_on) begin
            miso     = out_byte[7];
            out_byte = out_byte << 1;
            out_cnt++;
            if (out_cnt == 8) begin
                out_cnt = 0;
                if (op == OP_READ) begin
                    out_addr++;
                    out_byte = read_byte(out_addr);
                end else begin
                    out_byte = status_byte();
                end
            end
        end
    end

    ////////////////////
    // Command completion on CS rise

    always @(posedge cs_n) begin
        if (nbits > 0) begin
            if (op == OP_WREN && nbits == OP_BITS) begin
                wel = 1'b1;
            end else if (op == OP_SE && nbits == CMD_BITS) begin
                if (!wel)
                    violation("sector erase sent without a write enable before it");
                for (int i = 0; i < 4096; i++)
                    if (mem.exists({addr[ADDR_BITS-1:12], 12'(i)}))
                        mem.delete({addr[ADDR_BITS-1:12], 12'(i)});
                wel      = 1'b0;
                wip_left = $urandom_range(MAX_WIP_POLLS, 1);
            end else if (op == OP_PP && nbits > CMD_BITS) begin
                if (!wel)
                    violation("page program sent without a write enable before it");
                wel      = 1'b0;
                wip_left = $urandom_range(MAX_WIP_POLLS, 1);
            end else if (op == OP_RDSR && nbits > OP_BITS) begin
                if (wip_left > 0)
                    wip_left--;
                else
                    clear_replies++;
            end else if (!(op == OP_READ && nbits >= CMD_BITS)) begin
                violation($sformatf("frame with opcode %02h ended after %0d bits", op, nbits));
            end
        end
        nbits   = 0;
        out_on  = 1'b0;
        out_cnt = 0;
    end

endmodule

// ==== verification/flash_ctrl_assert.sv ====
module flash_ctrl_assert (
    input logic i_clk,
    input logic i_reset,
    input logic busy,
    input logic rd_valid,
    input logic qspi_cs_n,
    input logic qspi_sck
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;     // Assertion failures so far

    // Chip select only drops inside an operation
    cs_idle_high: assert property (
        @(posedge i_clk) disable iff (i_reset) !busy |-> qspi_cs_n
    ) else begin
        $error("qspi_cs_n is low while busy is low");
        fail_count++;
    end

    sck_idle_low: assert property (
        @(posedge i_clk) disable iff (i_reset) qspi_cs_n |-> !qspi_sck
    ) else begin
        $error("qspi_sck is high while qspi_cs_n is high");
        fail_count++;
    end

    rd_valid_pulse: assert property (
        @(posedge i_clk) disable iff (i_reset) rd_valid |=> !rd_valid
    ) else begin
        $error("rd_valid lasted more than one cycle");
        fail_count++;
    end

    rd_valid_busy: assert property (
        @(posedge i_clk) disable iff (i_reset) rd_valid |-> busy
    ) else begin
        $error("rd_valid pulsed while busy is low");
        fail_count++;
    end

endmodule

// ==== verification/tb_flash_ctrl.sv ====
module tb_flash_ctrl
    import flash_cmd_pkg::*;
    import spi_link_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PRESCALE      = 4;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int WIP_POLLS_MAX = 5;
    localparam int SEED          = 91582;
    localparam int CMD_BITS      = OP_BITS + ADDR_BITS;
    localparam int POLL_BITS     = OP_BITS + SR_BITS;
    // WREN, SE, WREN, PP with one word, and two passes of worst-case polling
    localparam int WRITE_BITS    = 2*OP_BITS + 2*CMD_BITS + WORD_BITS
                                   + 2*(WIP_POLLS_MAX+1)*POLL_BITS;
    localparam int WRITE_FRAMES  = 5 + 2*(WIP_POLLS_MAX+1);

    logic                 i_clk;
    logic                 i_reset;
    logic                 start, op_cont, is_write;
    logic [ADDR_BITS-1:0] address;
    logic [WORD_BITS-1:0] wr_word;
    logic [WORD_BITS-1:0] rd_word;
    logic                 rd_valid, busy;
    logic                 qspi_cs_n, qspi_sck, qspi_mosi, qspi_miso;

    string                kinds[$];
    logic [ADDR_BITS-1:0] addrs[$];
    logic [WORD_BITS-1:0] words[$];
    int                   counts[$];
    logic [WORD_BITS-1:0] ref_mem [logic [ADDR_BITS-1:0]];   // Expected flash words
    int                   limit_ns = 0;
    int                   lvl_len = 0;
    bit                   lvl_ok = 1'b0;
    logic                 sck_q, cs_q;

    flash_ctrl_top #(
        .PRESCALE (PRESCALE)
    ) u_dut (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .start     (start),
        .op_cont   (op_cont),
        .is_write  (is_write),
        .address   (address),
        .wr_word   (wr_word),
        .rd_word   (rd_word),
        .rd_valid  (rd_valid),
        .busy      (busy),
        .qspi_cs_n (qspi_cs_n),
        .qspi_sck  (qspi_sck),
        .qspi_mosi (qspi_mosi),
        .qspi_miso (qspi_miso)
    );

    flash_model #(
        .MAX_WIP_POLLS (WIP_POLLS_MAX)
    ) u_model (
        .cs_n (qspi_cs_n),
        .sck  (qspi_sck),
        .mosi (qspi_mosi),
        .miso (qspi_miso)
    );

    bind flash_ctrl_top flash_ctrl_assert u_assert (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .qspi_cs_n (qspi_cs_n),
        .qspi_sck  (qspi_sck)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    ////////////////////
    // Reporting and compares

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_BITS-1:0] got, exp);
        if (got !== exp)
            stop_run($sformatf("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp)
            stop_run($sformatf("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, exp);
        if (got != exp)
            stop_run($sformatf("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
    endtask

    function automatic logic [WORD_BITS-1:0] ref_word(input logic [ADDR_BITS-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : '1;   // Erased flash reads ones
    endfunction

    ////////////////////
    // Vectors and operations

    task automatic read_vectors();
        int                   fd;
        int                   n;
        string                line;
        string                kind;
        logic [ADDR_BITS-1:0] a;
        logic [WORD_BITS-1:0] d;
        fd = $fopen("verification/flash_vectors.txt", "r");
        if (fd == 0)
            stop_run("could not open verification/flash_vectors.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#"
                    && $sscanf(line, "%s %h %h %d", kind, a, d, n) == 4) begin
                kinds.push_back(kind);
                addrs.push_back(a);
                words.push_back(d);
                counts.push_back(n);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_read(input logic [ADDR_BITS-1:0] a,
                            input logic [WORD_BITS-1:0] first, input int n);
        int                   got;
        logic [WORD_BITS-1:0] exp;
        got      = 0;
        exp      = first;
        address  = a;
        is_write = 1'b0;
        op_cont  = (n > 1);
        start    = 1'b1;
        @(negedge i_clk);
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
        while (busy) begin
            if (rd_valid) begin
                exp = (got == 0) ? first : ref_word(a + ADDR_BITS'(4*got));
                check_word("rd_word", rd_word, exp);
                got++;
                op_cont = (got < n);    // Taken at this word boundary
            end
            @(negedge i_clk);
        end
        op_cont = 1'b0;
        check_count("rd_valid pulses", got, n);
        check_word("rd_word after read", rd_word, exp);
    endtask

    task automatic run_write(input logic [ADDR_BITS-1:0] a, input logic [WORD_BITS-1:0] d);
        int clears;
        clears   = u_model.clear_replies;
        address  = a;
        wr_word  = d;
        is_write = 1'b1;
        start    = 1'b1;
        @(negedge i_clk);
        start    = 1'b0;
        is_write = 1'b0;
        check_bit("busy", busy, 1'b1);
        while (busy)
            @(negedge i_clk);
        // One WIP clear reply after the erase and one after the program
        check_count("RDSR replies with WIP clear", u_model.clear_replies - clears, 2);
        check_count("model WIP polls left", u_model.wip_left, 0);
        for (int i = 0; i < 4096; i += 4)
            if (ref_mem.exists({a[ADDR_BITS-1:12], 12'(i)}))
                ref_mem.delete({a[ADDR_BITS-1:12], 12'(i)});
        ref_mem[a] = d;     // Programmed into an erased sector
    endtask

    ////////////////////
    // SCK level length at the pin

    always @(negedge i_clk) begin
        if (!i_reset) begin
            if (qspi_sck !== sck_q && !cs_q) begin
                if (lvl_ok)
                    check_count("qspi_sck level length", lvl_len, PRESCALE);
                lvl_len = 1;
                lvl_ok  = 1'b1;
            end else begin
                lvl_len++;
            end
            if (qspi_cs_n) begin
                lvl_ok = 1'b0;
            end else if (cs_q) begin
                lvl_len = 1;    // Frame begins with SCK low
                lvl_ok  = 1'b1;
            end
            if (u_dut.frame_done)
                lvl_ok = 1'b0;  // Low level spans a chained frame boundary
        end
        sck_q = qspi_sck;
        cs_q  = qspi_cs_n;
    end

    // Bound checker failures
    always @(negedge i_clk) begin
        if (u_dut.u_assert.fail_count != 0)
            stop_run("a concurrent assertion bound into the DUT did not hold");
    end

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        stop_run($sformatf("timeout, operations not finished after %0d ns", limit_ns));
    end

    initial begin
        int bits;
        int frames;
        i_clk    = 1'b0;
        i_reset  = 1'b1;
        start    = 1'b0;
        op_cont  = 1'b0;
        is_write = 1'b0;
        address  = '0;
        wr_word  = '0;
        bits     = 0;
        frames   = 0;
        void'($urandom(SEED));
        read_vectors();
        foreach (kinds[i]) begin
            if (kinds[i] == "R") begin
                bits   += CMD_BITS + counts[i] * WORD_BITS;
                frames += counts[i] + 2;
            end else if (kinds[i] == "W") begin
                bits   += WRITE_BITS;
                frames += WRITE_FRAMES;
            end
        end
        limit_ns = 2 * CLK_PERIOD * (bits * 2 * PRESCALE + frames * (PRESCALE + 4))
                   + CLK_PERIOD * (RESET_CYCLES + 100);

        repeat (RESET_CYCLES) @(negedge i_clk);
        i_reset = 1'b0;
        check_bit("busy", busy, 1'b0);
        check_bit("rd_valid", rd_valid, 1'b0);
        check_bit("qspi_cs_n", qspi_cs_n, 1'b1);
        check_bit("qspi_sck", qspi_sck, 1'b0);

        foreach (kinds[i]) begin
            case (kinds[i])
                "P": begin
                    u_model.load_word(addrs[i], words[i]);
                    ref_mem[addrs[i]] = words[i];
                end
                "R": run_read(addrs[i], words[i], counts[i]);
                "W": run_write(addrs[i], words[i]);
                default: stop_run({"unknown operation in vector file: ", kinds[i]});
            endcase
            if (u_model.proto_err)
                stop_run({"flash model saw a protocol violation: ", u_model.proto_msg});
            @(negedge i_clk);
        end

        if (u_dut.u_assert.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run("a concurrent assertion bound into the DUT did not hold");
        end
    end

endmodule

// ==== verification/flash_vectors.txt ====
# kind addr data count: P preloads a word, W writes one word, R reads count words
# For R the data column is the first word expected back
P 000100 A1B2C3D4 1
P 000104 11223344 1
P 000108 55667788 1
P 00010C 99AABBCC 1
R 000100 A1B2C3D4 1
R 000100 A1B2C3D4 4
W 000104 CAFEF00D 1
R 000104 CAFEF00D 1
R 000100 FFFFFFFF 3
W 002000 0BADBEEF 1
R 002000 0BADBEEF 2

// ==== project.f ====
rtl/flash_cmd_pkg.sv
rtl/spi_link_pkg.sv
rtl/spi_engine.sv
rtl/flash_seq.sv
rtl/flash_ctrl_top.sv
verification/flash_model.sv
verification/flash_ctrl_assert.sv
verification/tb_flash_ctrl.sv

// ==== Bender.yml ====
package:
  name: flash_ctrl

sources:
  - files:
      - rtl/flash_cmd_pkg.sv
      - rtl/spi_link_pkg.sv
      - rtl/spi_engine.sv
      - rtl/flash_seq.sv
      - rtl/flash_ctrl_top.sv
  - target: simulation
    files:
      - verification/flash_model.sv
      - verification/flash_ctrl_assert.sv
      - verification/tb_flash_ctrl.sv
